//--- Makefile
SIM := obj_dir/Vtb_cpu_on_board

.PHONY: all run clean

all: run

# rebuilt only when a listed source or the file list changes
$(SIM): src.f $(wildcard logic/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_cpu_on_board -f src.f -o Vtb_cpu_on_board

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/board_properties.sv
`timescale 1ns/1ps
`default_nettype none

module board_properties import board_pkg::*; (
    input wire        clk,
    input wire        rst_n,
    input bus_req_t   bus_req,
    input bus_rsp_t   bus_rsp,
    input wire  [3:0] irq_vector,
    input wire        txd,
    input wire        busy
);

    // counted so the testbench can see a failed property at the end
    int violations = 0;

    // read answered exactly one cycle later
    read_answered: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req.read |=> bus_rsp.rvalid)
        else begin violations++; $error("rvalid missing after read strobe"); end

    // and never without a read the cycle before
    rvalid_from_read: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp.rvalid |-> $past(bus_req.read))
        else begin violations++; $error("rvalid without a read strobe"); end

    vector_legal: assert property (@(posedge clk) disable iff (!rst_n)
        irq_vector == 4'd0 || irq_vector == key_vector)
        else begin violations++; $error("irq_vector holds an unknown vector"); end

    // serial line idles high
    txd_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> txd)
        else begin violations++; $error("txd low while console idle"); end

    no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus_req.read && bus_req.write))
        else begin violations++; $error("read and write strobes together"); end

endmodule

`default_nettype wire

//--- dv/tb_cpu_on_board.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_on_board import board_pkg::*; ();

    // system cycles per half PS/2 clock period
    localparam int ps2_half = 8;
    localparam int wait_limit = 4000;

    logic       CLOCK_50;
    logic       KEY0;
    logic       PS2_CLK;
    logic       PS2_DAT;
    bus_req_t   bus_req;
    logic       irq_ack;
    bus_rsp_t   bus_rsp;
    logic [3:0] irq_vector;
    logic [7:0] LEDG;
    logic       LEDR7;
    logic       UART_TXD;

    // expected board state
    logic [31:0] ram_model [logic [9:0]];
    logic [7:0]  key_model;
    logic [7:0]  led_model;
    logic        irq_en_model;
    logic [15:0] baud_model;
    logic        busy_model;
    logic [31:0] rng;

    // set 2 make codes, a to z, then 0 to 9
    logic [7:0] letter_codes [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33,
        8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
    logic [7:0] digit_codes [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D,
        8'h3E, 8'h46};

    cpu_on_board dut_i (.*);

    bind cpu_on_board board_properties props_i (.clk(CLOCK_50), .rst_n(KEY0),
        .bus_req(bus_req), .bus_rsp(bus_rsp), .irq_vector(irq_vector), .txd(UART_TXD),
        .busy(console_busy));

    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] ascii_of(input logic [7:0] code);
        logic [7:0] result;
        // space and enter, zero for anything unknown
        result = (code == 8'h29) ? 8'h20 : (code == 8'h5A) ? 8'h0D : 8'h00;
        for (int i = 0; i < 26; i++) begin
            if (letter_codes[i] == code) begin
                result = 8'h61 + 8'(i);
            end
        end
        for (int i = 0; i < 10; i++) begin
            if (digit_codes[i] == code) begin
                result = 8'h30 + 8'(i);
            end
        end
        return result;
    endfunction

    function automatic bus_rsp_t bus_expect(input logic [15:0] addr);
        bus_rsp_t exp;
        exp.rvalid = 1'b1;
        case (addr)
            key_addr: exp.rdata = {24'h0, key_model};
            console_addr: exp.rdata = {31'h0, busy_model};
            led_addr: exp.rdata = {24'h0, led_model};
            irq_ctrl_addr: exp.rdata = {31'h0, irq_en_model};
            baud_addr: exp.rdata = {16'h0, baud_model};
            default: exp.rdata = (addr[15:12] == 4'h0) ? ram_model[addr[11:2]] : 32'hDEADBEEF;
        endcase
        return exp;
    endfunction

    // line levels of an 8N1 frame, index 0 is the start bit
    function automatic logic [9:0] uart_frame_bits(input logic [7:0] data);
        return {1'b1, data, 1'b0};
    endfunction

    task automatic report_mismatch(input string what);
        $display("FAILED at %0t: %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_timeout(input string what);
        $display("timed out at %0t while waiting for %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: rdata %h rvalid %b, expected %h %b", what,
                got.rdata, got.rvalid, exp.rdata, exp.rvalid));
        end
    endtask

    // valid carries the pending led here
    task automatic check_key(input key_event_t got, input key_event_t exp,
                             input logic [3:0] got_vec, input logic [3:0] exp_vec,
                             input string what);
        if (got !== exp || got_vec !== exp_vec) begin
            report_mismatch($sformatf("%s: key %h pending %b vector %0d, expected %h %b %0d",
                what, got.ascii, got.valid, got_vec, exp.ascii, exp.valid, exp_vec));
        end
    endtask

    task automatic check_serial(input logic [9:0] got, input logic [9:0] exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: line bits %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_leds(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("LEDG %h, expected %h", got, exp));
        end
    endtask

    // bus tasks start and end on a falling edge
    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        bus_req.addr = addr;
        bus_req.wdata = data;
        bus_req.write = 1'b1;
        @(negedge CLOCK_50);
        bus_req.write = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output bus_rsp_t rsp);
        int cycles;
        bus_req.addr = addr;
        bus_req.read = 1'b1;
        @(negedge CLOCK_50);
        bus_req.read = 1'b0;
        cycles = 1;
        while (!bus_rsp.rvalid) begin
            if (cycles == 8) begin
                report_timeout("read data valid");
            end
            @(negedge CLOCK_50);
            cycles++;
        end
        if (cycles != 1) begin
            report_mismatch($sformatf("rvalid after %0d cycles, expected 1", cycles));
        end
        rsp = bus_rsp;
    endtask

    task automatic read_check(input logic [15:0] addr, input string what);
        bus_rsp_t rsp;
        bus_read(addr, rsp);
        check_rsp(rsp, bus_expect(addr), what);
    endtask

    // start, 8 data bits lsb first, odd parity, stop
    task automatic ps2_send(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            PS2_DAT = frame[i];
            repeat (ps2_half) @(negedge CLOCK_50);
            PS2_CLK = 1'b0;
            repeat (ps2_half) @(negedge CLOCK_50);
            PS2_CLK = 1'b1;
        end
        PS2_DAT = 1'b1;
        repeat (ps2_half) @(negedge CLOCK_50);
    endtask

    task automatic wait_vector(input logic [3:0] exp, input string what);
        int cycles;
        cycles = 0;
        while (irq_vector !== exp) begin
            if (cycles == wait_limit) begin
                report_timeout(what);
            end
            @(negedge CLOCK_50);
            cycles++;
        end
    endtask

    task automatic wait_key(input logic [7:0] exp);
        bus_rsp_t rsp;
        int tries;
        tries = 0;
        bus_read(key_addr, rsp);
        while (rsp.rdata[7:0] !== exp) begin
            if (tries == 50) begin
                report_timeout("key register update");
            end
            bus_read(key_addr, rsp);
            tries++;
        end
    endtask

    // key unchanged, no interrupt
    task automatic expect_quiet(input string what);
        bus_rsp_t rsp;
        repeat (8) @(negedge CLOCK_50);
        bus_read(key_addr, rsp);
        check_key({LEDR7, rsp.rdata[7:0]}, {1'b0, key_model}, irq_vector, 4'd0, what);
    endtask

    task automatic press_and_ack(input logic [7:0] code);
        bus_rsp_t rsp;
        ps2_send(code, 1'b0);
        wait_vector(key_vector, "key interrupt");
        key_model = ascii_of(code);
        bus_read(key_addr, rsp);
        check_rsp(rsp, bus_expect(key_addr), "key register");
        check_key({LEDR7, rsp.rdata[7:0]}, {1'b1, key_model}, irq_vector, key_vector, "press");
        irq_ack = 1'b1;
        @(negedge CLOCK_50);
        irq_ack = 1'b0;
        wait_vector(4'd0, "interrupt clear");
        check_key({LEDR7, rsp.rdata[7:0]}, {1'b0, key_model}, irq_vector, 4'd0, "ack");
    endtask

    // samples each bit at its middle, cycle 0 is the edge that took the write
    task automatic capture_frame(input int div, output logic [9:0] bits);
        for (int c = 0; c < 10 * div; c++) begin
            if (c % div == div / 2) begin
                bits[c / div] = UART_TXD;
            end
            @(negedge CLOCK_50);
        end
    endtask

    initial begin
        logic [15:0] addr;
        logic [15:0] addr_q [$];
        logic [7:0]  code;
        logic [9:0]  bits;
        int          div;
        KEY0 = 1'b0;
        PS2_CLK = 1'b1;
        PS2_DAT = 1'b1;
        bus_req = '0;
        irq_ack = 1'b0;
        rng = 32'd34;
        key_model = 8'h00;
        led_model = 8'h00;
        irq_en_model = 1'b0;
        baud_model = 16'd434;
        busy_model = 1'b0;
        repeat (10) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        @(negedge CLOCK_50);
        read_check(baud_addr, "divisor after reset");

        // ram writes, each read back on the next cycle, then a sweep
        for (int i = 0; i < 16; i++) begin
            rng = xorshift(rng);
            addr = {4'h0, rng[9:0], 2'b00};
            rng = xorshift(rng);
            bus_write(addr, rng);
            ram_model[addr[11:2]] = rng;
            addr_q.push_back(addr);
            read_check(addr, "ram readback");
        end
        foreach (addr_q[i]) begin
            read_check(addr_q[i], "ram sweep");
        end
        read_check(16'h8000, "unmapped read");

        rng = xorshift(rng);
        bus_write(led_addr, rng);
        led_model = rng[7:0];
        check_leds(LEDG, led_model);
        read_check(led_addr, "led readback");

        // keyboard with the interrupt enabled
        bus_write(irq_ctrl_addr, 32'd1);
        irq_en_model = 1'b1;
        rng = xorshift(rng);
        press_and_ack(letter_codes[rng % 26]);
        rng = xorshift(rng);
        press_and_ack(digit_codes[rng % 10]);

        // break, extended, unknown and bad parity frames
        ps2_send(8'hF0, 1'b0);
        ps2_send(letter_codes[3], 1'b0);
        expect_quiet("break sequence");
        ps2_send(8'hE0, 1'b0);
        ps2_send(8'h5A, 1'b0);
        expect_quiet("extended code");
        ps2_send(8'h76, 1'b0);
        expect_quiet("unknown code");
        ps2_send(letter_codes[7], 1'b1);
        expect_quiet("bad parity");

        // space key with the interrupt disabled
        bus_write(irq_ctrl_addr, 32'd0);
        irq_en_model = 1'b0;
        read_check(irq_ctrl_addr, "irq enable cleared");
        ps2_send(8'h29, 1'b0);
        key_model = ascii_of(8'h29);
        wait_key(key_model);
        expect_quiet("interrupt disabled");

        // console frame, with a busy read and a dropped second write
        rng = xorshift(rng);
        div = 4 + int'(rng % 13);
        bus_write(baud_addr, 32'(div));
        baud_model = 16'(div);
        read_check(baud_addr, "divisor write");
        rng = xorshift(rng);
        code = rng[7:0];
        bus_write(console_addr, {24'h0, code});
        fork
            capture_frame(div, bits);
            begin
                busy_model = 1'b1;
                read_check(console_addr, "busy during frame");
                bus_write(console_addr, {24'h0, ~code});
            end
        join
        check_serial(bits, uart_frame_bits(code), "console frame");
        busy_model = 1'b0;
        read_check(console_addr, "busy after frame");
        capture_frame(div, bits);
        check_serial(bits, 10'h3FF, "line after dropped write");

        if (dut_i.props_i.violations == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("%0d assertion failures", dut_i.props_i.violations);
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

//--- logic/board_bus.sv
`timescale 1ns/1ps
`default_nettype none

module board_bus import board_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  bus_req_t    req,
    output bus_rsp_t    rsp,
    input  wire  [7:0]  key_ascii,
    input  wire  [31:0] regs_rdata,
    input  wire         console_busy,
    output logic        regs_we,
    output logic        console_we,
    output logic [31:0] wdata,
    output logic [15:0] reg_addr
);

    logic [31:0] mem [ram_size_words];

    logic                     ram_sel;
    logic                     key_sel;
    logic                     console_sel;
    logic                     reg_sel;
    logic [ram_addr_bits-1:0] word_idx;
    logic [31:0]              read_mux;
    logic [31:0]              rdata_q;
    logic                     rvalid_q;

    // ram fills the bottom 4 KB
    assign ram_sel = (req.addr[15:12] == 4'h0);
    assign key_sel = (req.addr == key_addr);
    assign console_sel = (req.addr == console_addr);
    // led, irq enable and divisor all live in io_regs
    assign reg_sel = (req.addr == led_addr) || (req.addr == irq_ctrl_addr) ||
                     (req.addr == baud_addr);
    assign word_idx = req.addr[ram_addr_bits+1:2];

    // write strobes act on the same edge as the request
    assign regs_we = req.write && reg_sel;
    assign console_we = req.write && console_sel;
    assign wdata = req.wdata;
    assign reg_addr = req.addr;

    // read source select
    always_comb begin
        if (ram_sel) begin
            read_mux = mem[word_idx];
        end else if (key_sel) begin
            read_mux = {24'h000000, key_ascii};
        end else if (console_sel) begin
            read_mux = {31'h00000000, console_busy};
        end else if (reg_sel) begin
            read_mux = regs_rdata;
        end else begin
            read_mux = unmapped_data;
        end
    end

    // memory write and read data capture
    always_ff @(posedge clk) begin
        if (req.write && ram_sel) begin
            mem[word_idx] <= req.wdata;
        end
        if (req.read) begin
            rdata_q <= read_mux;
        end
    end

    // rvalid one cycle after the read strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req.read;
        end
    end

    assign rsp.rdata = rdata_q;
    assign rsp.rvalid = rvalid_q;

endmodule

`default_nettype wire

//--- logic/board_pkg.sv
`default_nettype none

package board_pkg;

    // memory: 1024 words of 32 bits, byte addresses 0x0000 to 0x0FFF
    localparam int ram_size_words = 1024;
    localparam int ram_addr_bits = 10;

    // memory-mapped I/O
    localparam logic [15:0] baud_addr = 16'hFFEC;
    localparam logic [15:0] key_addr = 16'hFFF0;
    localparam logic [15:0] console_addr = 16'hFFF4;
    localparam logic [15:0] led_addr = 16'hFFF8;
    localparam logic [15:0] irq_ctrl_addr = 16'hFFFC;

    // read data of any address that nothing answers
    localparam logic [31:0] unmapped_data = 32'hDEADBEEF;

    // 50 MHz / 434 is roughly 115200 baud
    localparam logic [15:0] baud_reset = 16'd434;
    localparam logic [3:0] key_vector = 4'd1;

    // about 1 ms of clock cycles at 50 MHz
    localparam logic [15:0] ps2_timeout = 16'd50000;

    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] wdata;
        logic        write;
        logic        read;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        rvalid;
    } bus_rsp_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] ascii;
    } key_event_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] code;
        logic       parity_ok;
    } scan_t;

    typedef enum logic [1:0] {ps2_idle, ps2_data, ps2_parity, ps2_stop} ps2_state_e;
    typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;

endpackage

`default_nettype wire

//--- logic/console_tx.sv
`timescale 1ns/1ps
`default_nettype none

module console_tx import board_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         start,
    input  wire  [7:0]  data,
    input  wire  [15:0] baud_div,
    output logic        txd,
    output logic        busy
);

    tx_state_e   state;
    logic [7:0]  shift_q;
    logic [2:0]  bit_cnt;
    logic [15:0] cyc_cnt;
    // divisor held for the whole byte
    logic [15:0] div_q;
    logic        bit_end;

    assign bit_end = (cyc_cnt == div_q - 16'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= tx_idle;
            shift_q <= 8'h00;
            bit_cnt <= 3'd0;
            cyc_cnt <= 16'd0;
            div_q <= baud_reset;
        end else begin
            if (state == tx_idle) begin
                // writes while busy are dropped
                if (start) begin
                    state <= tx_start;
                    shift_q <= data;
                    div_q <= baud_div;
                    cyc_cnt <= 16'd0;
                    bit_cnt <= 3'd0;
                end
            end else if (bit_end) begin
                cyc_cnt <= 16'd0;
                case (state)
                    tx_start: state <= tx_data;
                    tx_data: begin
                        shift_q <= {1'b0, shift_q[7:1]};
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= tx_stop;
                        end
                    end
                    default: state <= tx_idle;
                endcase
            end else begin
                cyc_cnt <= cyc_cnt + 16'd1;
            end
        end
    end

    // line idles high, start bit low, data lsb first, stop high
    assign txd = (state == tx_start) ? 1'b0 :
                 (state == tx_data) ? shift_q[0] : 1'b1;
    assign busy = (state != tx_idle);

endmodule

`default_nettype wire

//--- logic/cpu_on_board.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_on_board import board_pkg::*; (
    input  wire        CLOCK_50,
    input  wire        KEY0,
    input  wire        PS2_CLK,
    input  wire        PS2_DAT,
    input  bus_req_t   bus_req,
    input  wire        irq_ack,
    output bus_rsp_t   bus_rsp,
    output wire  [3:0] irq_vector,
    output wire  [7:0] LEDG,
    output wire        LEDR7,
    output wire        UART_TXD
);

    // keyboard path
    scan_t       scan;
    key_event_t  key;
    logic [7:0]  key_ascii;
    // bus to peripherals
    logic [31:0] regs_rdata;
    logic        console_busy;
    logic        regs_we;
    logic        console_we;
    logic [31:0] wdata;
    logic [15:0] reg_addr;
    // register outputs
    logic        irq_enable;
    logic [15:0] baud_div;

    ps2_receiver ps2_i (
        .clk(CLOCK_50), .rst_n(KEY0), .ps2_clk(PS2_CLK), .ps2_dat(PS2_DAT), .scan(scan)
    );

    scan_decoder dec_i (.clk(CLOCK_50), .rst_n(KEY0), .scan(scan), .key(key));

    board_bus bus_i (
        .clk(CLOCK_50), .rst_n(KEY0), .req(bus_req), .rsp(bus_rsp),
        .key_ascii(key_ascii), .regs_rdata(regs_rdata), .console_busy(console_busy),
        .regs_we(regs_we), .console_we(console_we), .wdata(wdata), .reg_addr(reg_addr)
    );

    io_regs regs_i (
        .clk(CLOCK_50), .rst_n(KEY0), .we(regs_we), .reg_addr(reg_addr), .wdata(wdata),
        .rdata(regs_rdata), .leds(LEDG), .irq_enable(irq_enable), .baud_div(baud_div)
    );

    // pending level lights the red led
    key_irq irq_i (
        .clk(CLOCK_50), .rst_n(KEY0), .key(key), .irq_enable(irq_enable),
        .irq_ack(irq_ack), .key_ascii(key_ascii), .irq_vector(irq_vector),
        .pending(LEDR7)
    );

    // console sends the low byte of the written word
    console_tx tx_i (
        .clk(CLOCK_50), .rst_n(KEY0), .start(console_we), .data(wdata[7:0]),
        .baud_div(baud_div), .txd(UART_TXD), .busy(console_busy)
    );

endmodule

`default_nettype wire

//--- logic/io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_regs import board_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         we,
    input  wire  [15:0] reg_addr,
    input  wire  [31:0] wdata,
    output logic [31:0] rdata,
    output logic [7:0]  leds,
    output logic        irq_enable,
    output logic [15:0] baud_div
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            leds <= 8'h00;
            irq_enable <= 1'b0;
            baud_div <= baud_reset;
        end else if (we) begin
            case (reg_addr)
                led_addr: leds <= wdata[7:0];
                irq_ctrl_addr: irq_enable <= wdata[0];
                baud_addr: begin
                    // a zero divisor would stall the transmitter
                    if (wdata[15:0] == 16'd0) begin
                        baud_div <= 16'd1;
                    end else begin
                        baud_div <= wdata[15:0];
                    end
                end
                default: ;
            endcase
        end
    end

    // readback, zero-extended
    always_comb begin
        case (reg_addr)
            led_addr: rdata = {24'h000000, leds};
            irq_ctrl_addr: rdata = {31'h00000000, irq_enable};
            baud_addr: rdata = {16'h0000, baud_div};
            default: rdata = 32'h00000000;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/key_irq.sv
`timescale 1ns/1ps
`default_nettype none

module key_irq import board_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  key_event_t  key,
    input  wire         irq_enable,
    input  wire         irq_ack,
    output logic [7:0]  key_ascii,
    output logic [3:0]  irq_vector,
    output logic        pending
);

    // event seen last cycle, turns into the vector one edge later
    logic key_seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_ascii <= 8'h00;
            key_seen <= 1'b0;
        end else begin
            key_seen <= key.valid;
            if (key.valid) begin
                key_ascii <= key.ascii;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_vector <= 4'd0;
        end else if (key_seen && irq_enable) begin
            // set wins over a coincident ack
            irq_vector <= key_vector;
        end else if (irq_ack) begin
            irq_vector <= 4'd0;
        end
    end

    // level for the red led
    assign pending = (irq_vector != 4'd0);

endmodule

`default_nettype wire

//--- logic/ps2_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver import board_pkg::*; (
    input  wire   clk,
    input  wire   rst_n,
    input  wire   ps2_clk,
    input  wire   ps2_dat,
    output scan_t scan
);

    // two-flop synchronizers, plus one more stage on the clock for edges
    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       fall;

    ps2_state_e  state;
    logic [7:0]  shift_q;
    logic [2:0]  bit_cnt;
    logic        parity_q;
    logic [15:0] idle_cnt;
    logic        parity_good;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // device shifts data on the falling clock edge
    assign fall = clk_prev & ~clk_sync[1];

    // odd parity: data bits plus parity bit hold an odd count of ones
    assign parity_good = ^{shift_q, parity_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ps2_idle;
            shift_q <= 8'h00;
            bit_cnt <= 3'd0;
            parity_q <= 1'b0;
            idle_cnt <= 16'd0;
            scan <= '0;
        end else begin
            // single-cycle pulse
            scan.valid <= 1'b0;
            if (fall || state == ps2_idle) begin
                idle_cnt <= 16'd0;
            end else begin
                idle_cnt <= idle_cnt + 16'd1;
            end
            if (state != ps2_idle && idle_cnt == ps2_timeout) begin
                // stalled frame, give up and wait for a new start bit
                state <= ps2_idle;
            end else if (fall) begin
                case (state)
                    ps2_idle: begin
                        // start bit is low
                        if (!dat_sync[1]) begin
                            state <= ps2_data;
                            bit_cnt <= 3'd0;
                        end
                    end
                    ps2_data: begin
                        // lsb first
                        shift_q <= {dat_sync[1], shift_q[7:1]};
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= ps2_parity;
                        end
                    end
                    ps2_parity: begin
                        parity_q <= dat_sync[1];
                        state <= ps2_stop;
                    end
                    ps2_stop: begin
                        // bad parity or low stop bit drops the frame
                        if (dat_sync[1] && parity_good) begin
                            scan.valid <= 1'b1;
                            scan.code <= shift_q;
                            scan.parity_ok <= 1'b1;
                        end
                        state <= ps2_idle;
                    end
                    default: state <= ps2_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/scan_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module scan_decoder import board_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  scan_t      scan,
    output key_event_t key
);

    logic       break_pend;
    logic       ext_pend;
    logic [7:0] ascii;

    // set 2 make codes to ascii, zero for anything not in the table
    always_comb begin
        case (scan.code)
            8'h1C: ascii = "a";
            8'h32: ascii = "b";
            8'h21: ascii = "c";
            8'h23: ascii = "d";
            8'h24: ascii = "e";
            8'h2B: ascii = "f";
            8'h34: ascii = "g";
            8'h33: ascii = "h";
            8'h43: ascii = "i";
            8'h3B: ascii = "j";
            8'h42: ascii = "k";
            8'h4B: ascii = "l";
            8'h3A: ascii = "m";
            8'h31: ascii = "n";
            8'h44: ascii = "o";
            8'h4D: ascii = "p";
            8'h15: ascii = "q";
            8'h2D: ascii = "r";
            8'h1B: ascii = "s";
            8'h2C: ascii = "t";
            8'h3C: ascii = "u";
            8'h2A: ascii = "v";
            8'h1D: ascii = "w";
            8'h22: ascii = "x";
            8'h35: ascii = "y";
            8'h1A: ascii = "z";
            8'h45: ascii = "0";
            8'h16: ascii = "1";
            8'h1E: ascii = "2";
            8'h26: ascii = "3";
            8'h25: ascii = "4";
            8'h2E: ascii = "5";
            8'h36: ascii = "6";
            8'h3D: ascii = "7";
            8'h3E: ascii = "8";
            8'h46: ascii = "9";
            8'h29: ascii = 8'h20;
            8'h5A: ascii = 8'h0D;
            default: ascii = 8'h00;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            break_pend <= 1'b0;
            ext_pend <= 1'b0;
            key <= '0;
        end else begin
            key.valid <= 1'b0;
            if (scan.valid && scan.parity_ok) begin
                if (scan.code == 8'hF0) begin
                    break_pend <= 1'b1;
                end else if (scan.code == 8'hE0) begin
                    ext_pend <= 1'b1;
                end else if (break_pend || ext_pend) begin
                    // code after a prefix is swallowed
                    break_pend <= 1'b0;
                    ext_pend <= 1'b0;
                end else if (ascii != 8'h00) begin
                    key.valid <= 1'b1;
                    key.ascii <= ascii;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src.f
logic/board_pkg.sv
logic/ps2_receiver.sv
logic/scan_decoder.sv
logic/board_bus.sv
logic/io_regs.sv
logic/key_irq.sv
logic/console_tx.sv
logic/cpu_on_board.sv
dv/board_properties.sv
dv/tb_cpu_on_board.sv
